//--- list.f
+incdir+logic
logic/capture_pkg.sv
logic/csr_bus_master.sv
logic/pixel_fifo.sv
logic/line_monitor.sv
logic/command_sequencer.sv
logic/capture_top.sv
test/tb_capture.sv

//--- Makefile
BIN = obj_dir/Vtb_capture

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_capture -Mdir obj_dir
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tb_capture
	verilator --lint-only -f list.f --top-module capture_top

clean:
	rm -rf obj_dir

//--- test/tb_capture.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module tb_capture;

	localparam int PIX_TOTAL = 1200;
	localparam int LINE_LEN = 16;
	localparam int WATCHDOG_NS = (PIX_TOTAL * 4 + 3000) * 20;

	logic                     bus_clk;
	logic                     rst_n;
	logic                     cmd_req;
	capture_pkg::cmd_t        cmd_code;
	logic                     cmd_ack;
	capture_pkg::csr_bus_t    csr_bus;
	logic [`CAP_DATA_W-1:0]   readdata;
	capture_pkg::csi_stream_t csi;
	logic                     out_rd;
	logic [`CAP_DATA_W-1:0]   out_data;
	logic                     out_empty;
	logic [`CAP_ERR_W-1:0]    leds;

	// receiver register file as seen by the model
	logic [`CAP_DATA_W-1:0] regs [64];
	logic [`CAP_DATA_W-1:0] exp_data [$];
	logic [37:0]            exp_wr [$];
	logic [15:0]            lfsr;
	logic                   wr_q;
	logic                   rd_seen;
	int                     strobe_len;
	int                     off_writes;
	int                     mism_cnt;
	int                     fail_cnt;

	capture_top u_dut (
		.bus_clk   (bus_clk),
		.rst_n     (rst_n),
		.cmd_req   (cmd_req),
		.cmd_code  (cmd_code),
		.cmd_ack   (cmd_ack),
		.csr_bus   (csr_bus),
		.readdata  (readdata),
		.csi       (csi),
		.out_rd    (out_rd),
		.out_data  (out_data),
		.out_empty (out_empty),
		.leds      (leds)
	);

	always #10 bus_clk = ~bus_clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		mism_cnt++;
		$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
	endtask

	task automatic report_failure(input string msg);
		fail_cnt++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// one Fibonacci step per bit, taps 16 14 13 11
	function automatic logic [`CAP_PIXEL_W-1:0] rand_bits();
		logic [`CAP_PIXEL_W-1:0] v;
		v = '0;
		for (int i = 0; i < `CAP_PIXEL_W; i++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[`CAP_PIXEL_W-2:0], lfsr[0]};
		end
		return v;
	endfunction

	// receiver register model, readdata answers on the falling edge
	always @(negedge bus_clk)
	begin
		readdata <= regs[csr_bus.address];
	end

	always @(posedge bus_clk)
	begin
		if (rst_n)
		begin
			if (csr_bus.write)
			begin
				regs[csr_bus.address] <= csr_bus.writedata;
			end
			if (csr_bus.write && !wr_q)
			begin
				if (csr_bus.address == `CAP_REG_ENABLE && csr_bus.writedata == 32'd0)
				begin
					off_writes++;
				end
				if (exp_wr.size() == 0)
				begin
					report_failure("register write with none expected");
				end
				else
				begin
					assert (csr_bus.address == exp_wr[0][37:32])
					else report_mismatch("csr_bus.address", {26'd0, csr_bus.address},
						{26'd0, exp_wr[0][37:32]});
					assert (csr_bus.writedata == exp_wr[0][31:0])
					else report_mismatch("csr_bus.writedata", csr_bus.writedata, exp_wr[0][31:0]);
					void'(exp_wr.pop_front());
				end
				// enable-1 is only allowed once the host drained everything
				if (csr_bus.address == `CAP_REG_ENABLE && csr_bus.writedata == 32'd1)
				begin
					assert (out_empty)
					else report_failure("enable-1 write while the FIFO still held words");
				end
			end
			if (csr_bus.write || csr_bus.read)
			begin
				strobe_len++;
			end
			else if (strobe_len != 0)
			begin
				assert (strobe_len == 2)
				else report_mismatch("strobe length", strobe_len, 32'd2);
				strobe_len = 0;
			end
			wr_q = csr_bus.write;
		end
	end

	// scoreboard, word is valid the cycle after a pop
	always @(posedge bus_clk)
	begin
		if (rd_seen)
		begin
			if (exp_data.size() == 0)
			begin
				report_failure("FIFO delivered a word with none expected");
			end
			else
			begin
				assert (out_data == exp_data[0])
				else report_mismatch("out_data", out_data, exp_data[0]);
				void'(exp_data.pop_front());
			end
		end
		rd_seen <= rst_n && out_rd && !out_empty;
	end

	// ack rises one cycle after the request was seen
	a_ack_needs_req: assert property (@(posedge bus_clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else report_failure("cmd_ack rose without cmd_req");

	a_ack_drop: assert property (@(posedge bus_clk) disable iff (!rst_n)
		(cmd_ack && !cmd_req) |=> !cmd_ack)
		else report_failure("cmd_ack did not fall after cmd_req dropped");

	task automatic send_cmd(input logic [7:0] code);
		int t;
		t = 0;
		@(negedge bus_clk);
		cmd_code = capture_pkg::cmd_t'(code);
		cmd_req = 1'b1;
		while (!cmd_ack && t < 100)
		begin
			@(negedge bus_clk);
			t++;
		end
		if (!cmd_ack)
		begin
			report_failure("command was never acknowledged");
		end
		cmd_req = 1'b0;
		t = 0;
		while (cmd_ack && t < 100)
		begin
			@(negedge bus_clk);
			t++;
		end
	endtask

	task automatic drain_expected();
		int t;
		t = 0;
		while ((exp_data.size() != 0 || !out_empty) && t < 4000)
		begin
			@(negedge bus_clk);
			out_rd = !out_empty;
			t++;
		end
		@(negedge bus_clk);
		out_rd = 1'b0;
		if (exp_data.size() != 0)
		begin
			report_failure("FIFO did not deliver all expected words");
		end
	endtask

	task automatic send_pixels(input int n, input logic expect_push);
		int sent;
		int col;
		sent = 0;
		col = 0;
		while (sent < n)
		begin
			@(negedge bus_clk);
			csi = '0;
			// stray pixels go out whatever the receiver enable says
			if (regs[`CAP_REG_ENABLE][0] || !expect_push)
			begin
				csi.pixel = rand_bits();
				csi.pixel_valid = 1'b1;
				csi.ls = expect_push && (col == 0);
				csi.le = expect_push && (col == LINE_LEN - 1);
				if (expect_push)
				begin
					exp_data.push_back({{(`CAP_DATA_W-`CAP_PIXEL_W){1'b0}}, csi.pixel});
				end
				sent++;
				col = (col == LINE_LEN - 1) ? 0 : col + 1;
			end
		end
		@(negedge bus_clk);
		csi = '0;
	endtask

	task automatic pulse_framing(input logic start);
		@(negedge bus_clk);
		csi = '0;
		csi.fs = start;
		csi.fe = !start;
		@(negedge bus_clk);
		csi = '0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		bus_clk = 1'b0;
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd_code = capture_pkg::CMD_WR_ROWS;
		csi = '0;
		out_rd = 1'b0;
		readdata = '0;
		lfsr = 16'd57;
		wr_q = 1'b0;
		rd_seen = 1'b0;
		strobe_len = 0;
		off_writes = 0;
		mism_cnt = 0;
		fail_cnt = 0;
		for (int i = 0; i < 64; i++)
		begin
			regs[i] = '0;
		end
		repeat (2) @(negedge bus_clk);
		assert (!cmd_ack && !csr_bus.write && !csr_bus.read && out_empty && leds == 0)
		else report_failure("outputs not at reset values");
		rst_n = 1'b1;

		// geometry writes, read-back, and an unknown byte
		exp_wr.push_back({`CAP_REG_ROWS, `CAP_ROWS_DEFAULT});
		send_cmd(8'h61);
		exp_wr.push_back({`CAP_REG_COLS, `CAP_COLS_DEFAULT});
		send_cmd(8'h62);
		send_cmd(8'h7a);
		exp_data.push_back(`CAP_ROWS_DEFAULT);
		send_cmd(8'h64);
		exp_data.push_back(`CAP_COLS_DEFAULT);
		send_cmd(8'h65);
		exp_data.push_back(32'd0);
		send_cmd(8'h66);
		drain_expected();

		// arm, strays before fs must not land in the FIFO
		exp_wr.push_back({`CAP_REG_ENABLE, 32'd1});
		send_cmd(8'h63);
		while (!regs[`CAP_REG_ENABLE][0])
		begin
			@(negedge bus_clk);
		end
		send_pixels(3, 1'b0);
		pulse_framing(1'b1);

		// host stays away until the pause write, then drains
		exp_wr.push_back({`CAP_REG_ENABLE, 32'd0});
		exp_wr.push_back({`CAP_REG_ENABLE, 32'd1});
		fork
			send_pixels(PIX_TOTAL, 1'b1);
			begin
				wait (off_writes == 1);
				assert (exp_data.size() >= `CAP_ALMOST_FULL)
				else report_failure("pause write came before the almost-full mark");
				repeat (20) @(negedge bus_clk);
				drain_expected();
			end
		join
		drain_expected();
		assert (leds == 0)
		else report_mismatch("leds", {28'd0, leds}, 32'd0);

		// three line starts with no line end give two errors
		for (int i = 0; i < 3; i++)
		begin
			@(negedge bus_clk);
			csi.pixel = rand_bits();
			csi.pixel_valid = 1'b1;
			csi.ls = 1'b1;
			exp_data.push_back({{(`CAP_DATA_W-`CAP_PIXEL_W){1'b0}}, csi.pixel});
			@(negedge bus_clk);
			csi = '0;
		end
		assert (leds == 4'd2)
		else report_mismatch("leds", {28'd0, leds}, 32'd2);
		drain_expected();

		// frame end, later pixels dropped, then commands work again
		exp_wr.push_back({`CAP_REG_ENABLE, 32'd0});
		pulse_framing(1'b0);
		send_pixels(4, 1'b0);
		exp_data.push_back(32'd0);
		send_cmd(8'h66);
		drain_expected();
		assert (out_empty && exp_wr.size() == 0)
		else report_failure("words or register writes left over at the end");

		$display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
		if (mism_cnt == 0 && fail_cnt == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- logic/capture_top.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module capture_top (
	input  logic                     bus_clk,
	input  logic                     rst_n,
	input  logic                     cmd_req,
	input  capture_pkg::cmd_t        cmd_code,
	output logic                     cmd_ack,
	output capture_pkg::csr_bus_t    csr_bus,
	input  logic [`CAP_DATA_W-1:0]   readdata,
	input  capture_pkg::csi_stream_t csi,
	input  logic                     out_rd,
	output logic [`CAP_DATA_W-1:0]   out_data,
	output logic                     out_empty,
	output logic [`CAP_ERR_W-1:0]    leds
);

	logic                   op_start;
	capture_pkg::reg_op_t   op;
	logic                   op_done;
	logic [`CAP_DATA_W-1:0] op_rdata;
	logic                   capture_on;
	logic                   almost_full;
	logic                   rd_push;
	logic                   pix_push;
	logic                   fifo_push;
	logic [`CAP_DATA_W-1:0] fifo_wdata;

	// op stays latched in the sequencer until the next access, so is_write
	// still describes the finishing access at op_done
	assign rd_push  = op_done && !op.is_write;
	assign pix_push = capture_on && csi.pixel_valid;

	assign fifo_push  = rd_push || pix_push;
	assign fifo_wdata = rd_push ? op_rdata :
		{{(`CAP_DATA_W-`CAP_PIXEL_W){1'b0}}, csi.pixel};

	command_sequencer u_seq (
		.bus_clk     (bus_clk),
		.rst_n       (rst_n),
		.cmd_req     (cmd_req),
		.cmd_code    (cmd_code),
		.cmd_ack     (cmd_ack),
		.op_start    (op_start),
		.op          (op),
		.op_done     (op_done),
		.fs          (csi.fs),
		.fe          (csi.fe),
		.almost_full (almost_full),
		.fifo_empty  (out_empty),
		.capture_on  (capture_on)
	);

	csr_bus_master u_csr (
		.bus_clk  (bus_clk),
		.rst_n    (rst_n),
		.op_start (op_start),
		.op       (op),
		.csr_bus  (csr_bus),
		.readdata (readdata),
		.op_done  (op_done),
		.rdata    (op_rdata)
	);

	pixel_fifo u_fifo (
		.bus_clk     (bus_clk),
		.rst_n       (rst_n),
		.push        (fifo_push),
		.wdata       (fifo_wdata),
		.pop         (out_rd),
		.rdata       (out_data),
		.empty       (out_empty),
		.almost_full (almost_full)
	);

	line_monitor u_lines (
		.bus_clk    (bus_clk),
		.rst_n      (rst_n),
		.capture_on (capture_on),
		.ls         (csi.ls),
		.le         (csi.le),
		.err_count  (leds)
	);

	// register reads only run outside capture, so the mux never sees both
	a_one_source: assert property (@(posedge bus_clk) disable iff (!rst_n)
		!(rd_push && pix_push))
		else $error("read-back word and pixel pushed in the same cycle");

endmodule

//--- logic/command_sequencer.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module command_sequencer (
	input  logic                  bus_clk,
	input  logic                  rst_n,
	input  logic                  cmd_req,
	input  capture_pkg::cmd_t     cmd_code,
	output logic                  cmd_ack,
	output logic                  op_start,
	output capture_pkg::reg_op_t  op,
	input  logic                  op_done,
	input  logic                  fs,
	input  logic                  fe,
	input  logic                  almost_full,
	input  logic                  fifo_empty,
	output logic                  capture_on
);

	capture_pkg::seq_state_t state, state_nxt;
	capture_pkg::reg_op_t    op_nxt;
	logic                    start_nxt;
	logic                    ack_nxt;
	logic                    fe_pend;
	logic                    op_busy;

	function automatic capture_pkg::reg_op_t make_op(
		input logic                   is_write,
		input logic [`CAP_ADDR_W-1:0] addr,
		input logic [`CAP_DATA_W-1:0] wdata
	);
		capture_pkg::reg_op_t r;
		r.is_write = is_write;
		r.addr     = addr;
		r.wdata    = wdata;
		return r;
	endfunction

	// pixels are taken while streaming, during the enable-0 write and
	// during the enable-1 write so nothing is lost once the receiver restarts
	assign capture_on = (state == capture_pkg::STREAM) ||
		(state == capture_pkg::PAUSE_OFF) || (state == capture_pkg::PAUSE_ON);

	always_comb
	begin
		state_nxt = state;
		start_nxt = 1'b0;
		op_nxt    = op;
		ack_nxt   = cmd_ack;

		// four-phase handshake, ack follows req down one cycle later
		if (cmd_ack && !cmd_req)
		begin
			ack_nxt = 1'b0;
		end

		case (state)
			capture_pkg::IDLE:
			begin
				if (cmd_req && !cmd_ack)
				begin
					ack_nxt = 1'b1;
					start_nxt = 1'b1;
					case (cmd_code)
						capture_pkg::CMD_WR_ROWS:
						begin
							state_nxt = capture_pkg::WR_ROWS;
							op_nxt = make_op(1'b1, `CAP_REG_ROWS, `CAP_ROWS_DEFAULT);
						end
						capture_pkg::CMD_WR_COLS:
						begin
							state_nxt = capture_pkg::WR_COLS;
							op_nxt = make_op(1'b1, `CAP_REG_COLS, `CAP_COLS_DEFAULT);
						end
						capture_pkg::CMD_WR_ENABLE:
						begin
							state_nxt = capture_pkg::WR_ENABLE;
							op_nxt = make_op(1'b1, `CAP_REG_ENABLE, 32'd1);
						end
						capture_pkg::CMD_RD_ROWS:
						begin
							state_nxt = capture_pkg::RD_ROWS;
							op_nxt = make_op(1'b0, `CAP_REG_ROWS, '0);
						end
						capture_pkg::CMD_RD_COLS:
						begin
							state_nxt = capture_pkg::RD_COLS;
							op_nxt = make_op(1'b0, `CAP_REG_COLS, '0);
						end
						capture_pkg::CMD_RD_ENABLE:
						begin
							state_nxt = capture_pkg::RD_ENABLE;
							op_nxt = make_op(1'b0, `CAP_REG_ENABLE, '0);
						end
						default:
						begin
							// unknown byte, acked but no access
							start_nxt = 1'b0;
						end
					endcase
				end
			end
			capture_pkg::WR_ROWS, capture_pkg::WR_COLS,
			capture_pkg::RD_ROWS, capture_pkg::RD_COLS, capture_pkg::RD_ENABLE:
			begin
				if (op_done)
				begin
					state_nxt = capture_pkg::IDLE;
				end
			end
			capture_pkg::WR_ENABLE:
			begin
				if (op_done)
				begin
					state_nxt = capture_pkg::WAIT_FS;
				end
			end
			capture_pkg::WAIT_FS:
			begin
				if (fs)
				begin
					state_nxt = capture_pkg::STREAM;
				end
			end
			capture_pkg::STREAM:
			begin
				// frame end has priority over the fill level
				if (fe)
				begin
					state_nxt = capture_pkg::FRAME_OFF;
					start_nxt = 1'b1;
					op_nxt = make_op(1'b1, `CAP_REG_ENABLE, '0);
				end
				else if (almost_full)
				begin
					state_nxt = capture_pkg::PAUSE_OFF;
					start_nxt = 1'b1;
					op_nxt = make_op(1'b1, `CAP_REG_ENABLE, '0);
				end
			end
			capture_pkg::PAUSE_OFF:
			begin
				if (op_done)
				begin
					state_nxt = capture_pkg::DRAIN;
				end
			end
			capture_pkg::DRAIN:
			begin
				if (fifo_empty)
				begin
					// receiver already off, a frame that ended meanwhile is done
					if (fe_pend)
					begin
						state_nxt = capture_pkg::IDLE;
					end
					else
					begin
						state_nxt = capture_pkg::PAUSE_ON;
						start_nxt = 1'b1;
						op_nxt = make_op(1'b1, `CAP_REG_ENABLE, 32'd1);
					end
				end
			end
			capture_pkg::PAUSE_ON:
			begin
				if (op_done)
				begin
					if (fe_pend || fe)
					begin
						state_nxt = capture_pkg::FRAME_OFF;
						start_nxt = 1'b1;
						op_nxt = make_op(1'b1, `CAP_REG_ENABLE, '0);
					end
					else
					begin
						state_nxt = capture_pkg::STREAM;
					end
				end
			end
			capture_pkg::FRAME_OFF:
			begin
				if (op_done)
				begin
					state_nxt = capture_pkg::IDLE;
				end
			end
			default:
			begin
				state_nxt = capture_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge bus_clk)
	begin
		if (!rst_n)
		begin
			state    <= capture_pkg::IDLE;
			cmd_ack  <= 1'b0;
			op_start <= 1'b0;
			fe_pend  <= 1'b0;
			op_busy  <= 1'b0;
		end
		else
		begin
			state    <= state_nxt;
			cmd_ack  <= ack_nxt;
			op_start <= start_nxt;
			// a frame end seen outside STREAM is remembered until the next arm
			if (state == capture_pkg::WAIT_FS)
			begin
				fe_pend <= 1'b0;
			end
			else if (fe)
			begin
				fe_pend <= 1'b1;
			end
			if (op_start)
			begin
				op_busy <= 1'b1;
			end
			else if (op_done)
			begin
				op_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge bus_clk)
	begin
		op <= op_nxt;
	end

	// bus master handles one access at a time
	a_no_overlap: assert property (@(posedge bus_clk) disable iff (!rst_n)
		op_start |-> !op_busy)
		else $error("op_start while a register access is still running");

endmodule

//--- logic/line_monitor.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module line_monitor (
	input  logic                  bus_clk,
	input  logic                  rst_n,
	input  logic                  capture_on,
	input  logic                  ls,
	input  logic                  le,
	output logic [`CAP_ERR_W-1:0] err_count
);

	logic [`CAP_LINE_CNT_W-1:0] ls_cnt;
	logic [`CAP_LINE_CNT_W-1:0] le_cnt;
	logic                       line_open;

	// a line is still open when the counters disagree
	assign line_open = (ls_cnt != le_cnt);

	always_ff @(posedge bus_clk)
	begin
		if (!rst_n)
		begin
			ls_cnt    <= '0;
			le_cnt    <= '0;
			err_count <= '0;
		end
		else if (capture_on)
		begin
			if (ls)
			begin
				ls_cnt <= ls_cnt + 1'b1;
				// new line start before the previous line closed
				if (line_open)
				begin
					err_count <= err_count + 1'b1;
				end
			end
			if (le)
			begin
				le_cnt <= le_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/pixel_fifo.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module pixel_fifo #(
	parameter int DEPTH   = `CAP_FIFO_DEPTH,
	parameter int AW      = `CAP_FIFO_AW,
	parameter int AF_MARK = `CAP_ALMOST_FULL,
	parameter int W       = `CAP_DATA_W
) (
	input  logic         bus_clk,
	input  logic         rst_n,
	input  logic         push,
	input  logic [W-1:0] wdata,
	input  logic         pop,
	output logic [W-1:0] rdata,
	output logic         empty,
	output logic         almost_full
);

	logic [W-1:0]  mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign full        = (count == (AW+1)'(DEPTH));
	assign empty       = (count == '0);
	assign almost_full = (count >= (AW+1)'(AF_MARK));

	// overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge bus_clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// pointers wrap naturally since DEPTH is a power of two
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge bus_clk)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= wdata;
		end
		// registered read, word shows up the cycle after pop
		if (do_pop)
		begin
			rdata <= mem[rd_ptr];
		end
	end

	a_no_overflow: assert property (@(posedge bus_clk) disable iff (!rst_n)
		push |-> !full)
		else $error("push to full FIFO dropped");

	a_no_underflow: assert property (@(posedge bus_clk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("pop from empty FIFO");

endmodule

//--- logic/csr_bus_master.sv
`timescale 1ns/1ps
`include "capture_config.svh"

module csr_bus_master (
	input  logic                   bus_clk,
	input  logic                   rst_n,
	input  logic                   op_start,
	input  capture_pkg::reg_op_t   op,
	output capture_pkg::csr_bus_t  csr_bus,
	input  logic [`CAP_DATA_W-1:0] readdata,
	output logic                   op_done,
	output logic [`CAP_DATA_W-1:0] rdata
);

	// 0 idle, 1 and 2 strobe high, 3 done
	logic [1:0]           phase;
	capture_pkg::reg_op_t op_q;
	logic                 strobe;

	assign strobe  = (phase == 2'd1) || (phase == 2'd2);
	assign op_done = (phase == 2'd3);

	assign csr_bus.write     = strobe && op_q.is_write;
	assign csr_bus.read      = strobe && !op_q.is_write;
	assign csr_bus.address   = strobe ? op_q.addr : '0;
	assign csr_bus.writedata = strobe ? op_q.wdata : '0;

	always_ff @(posedge bus_clk)
	begin
		if (!rst_n)
		begin
			phase <= 2'd0;
		end
		else if (phase != 2'd0)
		begin
			// wraps from done back to idle
			phase <= phase + 2'd1;
		end
		else if (op_start)
		begin
			phase <= 2'd1;
		end
	end

	always_ff @(posedge bus_clk)
	begin
		if (op_start && phase == 2'd0)
		begin
			op_q <= op;
		end
		// receiver answers by the end of the second read cycle
		if (phase == 2'd2 && !op_q.is_write)
		begin
			rdata <= readdata;
		end
	end

	a_excl_strobe: assert property (@(posedge bus_clk) disable iff (!rst_n)
		!(csr_bus.write && csr_bus.read))
		else $error("write and read strobes high together");

	// a start in the middle of an access would be lost
	a_start_idle: assert property (@(posedge bus_clk) disable iff (!rst_n)
		op_start |-> (phase == 2'd0))
		else $error("register access requested while the bus was busy");

endmodule

//--- logic/capture_pkg.sv
`include "capture_config.svh"

package capture_pkg;

	// host command bytes, plain ASCII
	typedef enum logic [7:0] {
		CMD_WR_ROWS   = 8'h61,
		CMD_WR_COLS   = 8'h62,
		CMD_WR_ENABLE = 8'h63,
		CMD_RD_ROWS   = 8'h64,
		CMD_RD_COLS   = 8'h65,
		CMD_RD_ENABLE = 8'h66
	} cmd_t;

	typedef enum logic [3:0] {
		IDLE,
		WR_ROWS,
		WR_COLS,
		WR_ENABLE,
		RD_ROWS,
		RD_COLS,
		RD_ENABLE,
		WAIT_FS,
		STREAM,
		PAUSE_OFF,
		DRAIN,
		PAUSE_ON,
		FRAME_OFF
	} seq_state_t;

	// one receiver register access, handed from sequencer to bus master
	typedef struct packed {
		logic                   is_write;
		logic [`CAP_ADDR_W-1:0] addr;
		logic [`CAP_DATA_W-1:0] wdata;
	} reg_op_t;

	// receiver pixel stream with its framing strobes
	typedef struct packed {
		logic [`CAP_PIXEL_W-1:0] pixel;
		logic                    pixel_valid;
		logic                    fs;
		logic                    fe;
		logic                    ls;
		logic                    le;
	} csi_stream_t;

	// receiver register bus, master side
	typedef struct packed {
		logic                   write;
		logic                   read;
		logic [`CAP_ADDR_W-1:0] address;
		logic [`CAP_DATA_W-1:0] writedata;
	} csr_bus_t;

endpackage

//--- logic/capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// output FIFO word and receiver register data width
`define CAP_DATA_W 32

// RAW10 pixel from the receiver
`define CAP_PIXEL_W 10

// receiver register bus uses word addresses
`define CAP_ADDR_W 6

// receiver register map
`define CAP_REG_ENABLE 6'd0
`define CAP_REG_ROWS 6'd1
`define CAP_REG_COLS 6'd2

// default frame geometry written by the "a" and "b" commands
`define CAP_ROWS_DEFAULT 32'd1080
`define CAP_COLS_DEFAULT 32'd1920

// output FIFO geometry, depth must equal 2**AW
`define CAP_FIFO_DEPTH 1024
`define CAP_FIFO_AW 10

// fill level at which capture pauses
`define CAP_ALMOST_FULL 900

// line monitor widths
`define CAP_LINE_CNT_W 17
`define CAP_ERR_W 4

`endif
